/* source/csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// register and address widths
`define CSR_DATA_W 32
`define CSR_ADDR_W 14

// external hardware interrupt lines
`define CSR_HWI_N 8

// SAVE0..SAVE3
`define CSR_SAVE_N 4

`endif

/* source/csr_addr_pkg.sv */
`include "csr_cfg.svh"

package csr_addr_pkg;

    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // architectural CSR numbers
    typedef enum csr_addr_t {
        CSR_CRMD   = 'h0,
        CSR_PRMD   = 'h1,
        CSR_ECFG   = 'h4,
        CSR_ESTAT  = 'h5,
        CSR_ERA    = 'h6,
        CSR_EENTRY = 'hc,
        CSR_SAVE0  = 'h30,
        CSR_SAVE1  = 'h31,
        CSR_SAVE2  = 'h32,
        CSR_SAVE3  = 'h33,
        CSR_TCFG   = 'h41,
        CSR_TVAL   = 'h42,
        CSR_TICLR  = 'h44
    } csr_addr_e;

endpackage

/* source/csr_field_pkg.sv */
`include "csr_cfg.svh"

package csr_field_pkg;

    typedef logic [`CSR_DATA_W-1:0] csr_word_t;
    typedef logic [1:0]             plv_t;
    typedef logic [5:0]             ecode_t;
    typedef logic [12:0]            int_vec_t;

    // field low bit positions
    localparam int CRMD_PLV       = 0;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int CRMD_PG        = 4;
    localparam int PRMD_PPLV      = 0;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS       = 0;
    localparam int ESTAT_ECODE    = 16;
    localparam int ESTAT_ESUBCODE = 22;
    localparam int EENTRY_VA      = 6;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITVAL   = 2;
    localparam int TICLR_CLR      = 0;

    // LIE bit 10 does not exist on la32r
    localparam int_vec_t ECFG_LIE_MASK = 13'h1bff;

    function automatic csr_word_t masked_merge(input csr_word_t old_val,
                                               input csr_word_t new_val,
                                               input csr_word_t mask);
        return (old_val & ~mask) | (new_val & mask);
    endfunction

endpackage

/* source/csr_mode_ctrl.sv */
`include "csr_cfg.svh"

module csr_mode_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     software_we,
    input  csr_addr_pkg::csr_addr_e  waddr,
    input  csr_field_pkg::csr_word_t we,
    input  csr_field_pkg::csr_word_t wdata,
    input  logic                     store_state,
    input  logic                     restore_state,
    input  logic [6:0]               ecode_in,
    input  logic                     ecode_we,
    input  logic [`CSR_HWI_N-1:0]    hardware_int,
    input  logic                     timer_int,
    output csr_field_pkg::plv_t      plv,
    output csr_field_pkg::ecode_t    ecode,
    output logic [1:0]               translate_mode,
    output logic                     has_interrupt_cpu,
    output logic                     has_interrupt_idle,
    output csr_field_pkg::csr_word_t crmd_word,
    output csr_field_pkg::csr_word_t prmd_word,
    output csr_field_pkg::csr_word_t ecfg_word,
    output csr_field_pkg::csr_word_t estat_word
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    plv_t      crmd_plv;
    logic      crmd_ie;
    logic      crmd_da;
    logic      crmd_pg;
    plv_t      prmd_pplv;
    logic      prmd_pie;
    int_vec_t  ecfg_lie;
    logic [1:0] estat_is_sw;
    ecode_t    estat_ecode;
    logic      estat_esub;
    int_vec_t  is_vec;
    csr_word_t crmd_merged;
    csr_word_t prmd_merged;
    csr_word_t ecfg_merged;
    csr_word_t estat_merged;
    logic [1:0] pg_da_next;

    assign crmd_merged  = masked_merge(crmd_word, wdata, we);
    assign prmd_merged  = masked_merge(prmd_word, wdata, we);
    assign ecfg_merged  = masked_merge(ecfg_word, wdata, we);
    assign estat_merged = masked_merge(estat_word, wdata, we);
    assign pg_da_next   = {crmd_merged[CRMD_PG], crmd_merged[CRMD_DA]};

    ////////////////////////////////////////
    // register updates

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
            crmd_da  <= 1'b1;
            crmd_pg  <= 1'b0;
        end else if (restore_state) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (store_state) begin
            crmd_plv <= '0;
            crmd_ie  <= 1'b0;
        end else if (software_we && waddr == CSR_CRMD) begin
            crmd_plv <= crmd_merged[CRMD_PLV +: $bits(plv_t)];
            crmd_ie  <= crmd_merged[CRMD_IE];
            // only a one-hot translation mode is taken
            if (pg_da_next[1] ^ pg_da_next[0]) begin
                crmd_pg <= pg_da_next[1];
                crmd_da <= pg_da_next[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd_pplv <= '0;
            prmd_pie  <= 1'b0;
        end else if (store_state) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (software_we && waddr == CSR_PRMD) begin
            prmd_pplv <= prmd_merged[PRMD_PPLV +: $bits(plv_t)];
            prmd_pie  <= prmd_merged[PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ecfg_lie <= '0;
        end else if (software_we && waddr == CSR_ECFG) begin
            ecfg_lie <= ecfg_merged[$bits(int_vec_t)-1:0] & ECFG_LIE_MASK;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            estat_is_sw <= '0;
            estat_ecode <= '0;
            estat_esub  <= 1'b0;
        end else if (ecode_we) begin
            estat_ecode <= ecode_in[5:0];
            // subcode only for a real exception, zero for interrupts
            estat_esub  <= (|ecode_in[5:0]) ? ecode_in[6] : 1'b0;
        end else if (software_we && waddr == CSR_ESTAT) begin
            estat_is_sw <= estat_merged[ESTAT_IS +: 2];
        end
    end

    ////////////////////////////////////////
    // register words and outputs

    // IPI and bit 10 read 0
    assign is_vec = {1'b0, timer_int, 1'b0, hardware_int, estat_is_sw};

    always_comb begin
        crmd_word = '0;
        crmd_word[CRMD_PLV +: $bits(plv_t)] = crmd_plv;
        crmd_word[CRMD_IE] = crmd_ie;
        crmd_word[CRMD_DA] = crmd_da;
        crmd_word[CRMD_PG] = crmd_pg;
        prmd_word = '0;
        prmd_word[PRMD_PPLV +: $bits(plv_t)] = prmd_pplv;
        prmd_word[PRMD_PIE] = prmd_pie;
        ecfg_word = '0;
        ecfg_word[$bits(int_vec_t)-1:0] = ecfg_lie;
        estat_word = '0;
        estat_word[ESTAT_IS +: $bits(int_vec_t)] = is_vec;
        estat_word[ESTAT_ECODE +: $bits(ecode_t)] = estat_ecode;
        estat_word[ESTAT_ESUBCODE] = estat_esub;
    end

    assign plv                = crmd_plv;
    assign ecode              = estat_ecode;
    assign translate_mode     = {crmd_pg, crmd_da};
    assign has_interrupt_idle = |is_vec;
    assign has_interrupt_cpu  = crmd_ie & (|(is_vec & ecfg_lie));

    // pipeline never enters and leaves an exception at once
    a_no_store_restore: assert property (@(posedge clk) disable iff (!rstn)
        !(store_state && restore_state));

    a_pg_da_onehot: assert property (@(posedge clk) disable iff (!rstn)
        crmd_pg ^ crmd_da);

endmodule

/* source/csr_scratch_bank.sv */
`include "csr_cfg.svh"

module csr_scratch_bank (
    input  logic                                      clk,
    input  logic                                      rstn,
    input  logic                                      software_we,
    input  csr_addr_pkg::csr_addr_e                   waddr,
    input  csr_field_pkg::csr_word_t                  we,
    input  csr_field_pkg::csr_word_t                  wdata,
    input  csr_field_pkg::csr_word_t                  era_in,
    input  logic                                      era_we,
    output csr_field_pkg::csr_word_t                  era,
    output csr_field_pkg::csr_word_t                  eentry_word,
    output csr_field_pkg::csr_word_t [`CSR_SAVE_N-1:0] save_words
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    logic [`CSR_DATA_W-1:EENTRY_VA] eentry_va;
    csr_word_t eentry_merged;

    assign eentry_merged = masked_merge(eentry_word, wdata, we);
    // entry point is 64-byte aligned
    assign eentry_word   = {eentry_va, {EENTRY_VA{1'b0}}};

    // hardware return address wins over software
    always_ff @(posedge clk) begin
        if (!rstn) begin
            era <= '0;
        end else if (era_we) begin
            era <= era_in;
        end else if (software_we && waddr == CSR_ERA) begin
            era <= masked_merge(era, wdata, we);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
        end else if (software_we && waddr == CSR_EENTRY) begin
            eentry_va <= eentry_merged[`CSR_DATA_W-1:EENTRY_VA];
        end
    end

    // SAVE0..3 sit at consecutive addresses
    always_ff @(posedge clk) begin
        if (!rstn) begin
            save_words <= '0;
        end else if (software_we) begin
            for (int i = 0; i < `CSR_SAVE_N; i++) begin
                if (waddr == CSR_SAVE0 + i) begin
                    save_words[i] <= masked_merge(save_words[i], wdata, we);
                end
            end
        end
    end

endmodule

/* source/csr_timer.sv */
module csr_timer (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     software_we,
    input  csr_addr_pkg::csr_addr_e  waddr,
    input  csr_field_pkg::csr_word_t we,
    input  csr_field_pkg::csr_word_t wdata,
    output logic                     timer_int,
    output csr_field_pkg::csr_word_t tcfg_word,
    output csr_field_pkg::csr_word_t tval
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    csr_word_t tcfg_merged;
    csr_word_t load_val;
    csr_word_t reload_val;
    logic      tcfg_wr;
    logic      tcfg_load;
    logic      tval_step;
    logic      tval_reload;
    logic      tval_fire;
    logic      ticlr_hit;

    assign tcfg_wr     = software_we && (waddr == CSR_TCFG);
    assign tcfg_load   = tcfg_wr && (|we);
    assign tcfg_merged = masked_merge(tcfg_word, wdata, we);

    // count starts one above initval so that initval 0 still fires
    assign load_val    = {tcfg_merged[$bits(csr_word_t)-1:TCFG_INITVAL], 2'b01};
    assign reload_val  = {tcfg_word[$bits(csr_word_t)-1:TCFG_INITVAL], 2'b01};

    assign tval_step   = tcfg_word[TCFG_EN] && (tval != '0);
    assign tval_reload = tcfg_word[TCFG_PERIODIC] && (tval == '0);
    assign tval_fire   = !tcfg_load && tval_step && (tval == csr_word_t'(1));
    assign ticlr_hit   = software_we && (waddr == CSR_TICLR)
                         && we[TICLR_CLR] && wdata[TICLR_CLR];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg_word <= '0;
        end else if (tcfg_wr) begin
            tcfg_word <= tcfg_merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval <= '0;
        end else if (tcfg_load) begin
            tval <= load_val;
        end else if (tval_step) begin
            tval <= tval - 1'b1;
        end else if (tval_reload) begin
            tval <= reload_val;
        end
    end

    // clear has priority over a same-edge expiry
    always_ff @(posedge clk) begin
        if (!rstn) begin
            timer_int <= 1'b0;
        end else if (ticlr_hit) begin
            timer_int <= 1'b0;
        end else if (tval_fire) begin
            timer_int <= 1'b1;
        end
    end

    a_tval_no_rise: assert property (@(posedge clk) disable iff (!rstn)
        (!tcfg_load && tval != '0) |=> (tval <= $past(tval)));

endmodule

/* source/csr_read_port.sv */
`include "csr_cfg.svh"

module csr_read_port (
    input  csr_addr_pkg::csr_addr_e                   raddr_a,
    input  csr_addr_pkg::csr_addr_e                   raddr_b,
    input  csr_field_pkg::csr_word_t                  crmd_word,
    input  csr_field_pkg::csr_word_t                  prmd_word,
    input  csr_field_pkg::csr_word_t                  ecfg_word,
    input  csr_field_pkg::csr_word_t                  estat_word,
    input  csr_field_pkg::csr_word_t                  era,
    input  csr_field_pkg::csr_word_t                  eentry_word,
    input  csr_field_pkg::csr_word_t [`CSR_SAVE_N-1:0] save_words,
    input  csr_field_pkg::csr_word_t                  tcfg_word,
    input  csr_field_pkg::csr_word_t                  tval,
    output csr_field_pkg::csr_word_t                  rdata_a,
    output csr_field_pkg::csr_word_t                  rdata_b
);
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    function automatic csr_word_t read_mux(input csr_addr_e addr);
        case (addr)
            CSR_CRMD:   return crmd_word;
            CSR_PRMD:   return prmd_word;
            CSR_ECFG:   return ecfg_word;
            CSR_ESTAT:  return estat_word;
            CSR_ERA:    return era;
            CSR_EENTRY: return eentry_word;
            CSR_SAVE0:  return save_words[0];
            CSR_SAVE1:  return save_words[1];
            CSR_SAVE2:  return save_words[2];
            CSR_SAVE3:  return save_words[3];
            CSR_TCFG:   return tcfg_word;
            CSR_TVAL:   return tval;
            // write-only clear register
            CSR_TICLR:  return '0;
            default:    return '0;
        endcase
    endfunction

    // independent ports, no arbitration
    always_comb begin
        rdata_a = read_mux(raddr_a);
        rdata_b = read_mux(raddr_b);
    end

endmodule

/* source/csr_top.sv */
`include "csr_cfg.svh"

module csr_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     software_we,
    input  csr_addr_pkg::csr_addr_e  waddr,
    input  csr_field_pkg::csr_word_t we,
    input  csr_field_pkg::csr_word_t wdata,
    input  csr_addr_pkg::csr_addr_e  raddr_a,
    output csr_field_pkg::csr_word_t rdata_a,
    input  csr_addr_pkg::csr_addr_e  raddr_b,
    output csr_field_pkg::csr_word_t rdata_b,
    input  logic                     store_state,
    input  logic                     restore_state,
    input  logic [6:0]               ecode_in,
    input  logic                     ecode_we,
    input  csr_field_pkg::csr_word_t era_in,
    input  logic                     era_we,
    input  logic [`CSR_HWI_N-1:0]    hardware_int,
    output csr_field_pkg::plv_t      plv,
    output csr_field_pkg::ecode_t    ecode,
    output csr_field_pkg::csr_word_t era_out,
    output csr_field_pkg::csr_word_t eentry,
    output logic [1:0]               translate_mode,
    output logic                     has_interrupt_cpu,
    output logic                     has_interrupt_idle
);

    csr_field_pkg::csr_word_t                   crmd_word;
    csr_field_pkg::csr_word_t                   prmd_word;
    csr_field_pkg::csr_word_t                   ecfg_word;
    csr_field_pkg::csr_word_t                   estat_word;
    csr_field_pkg::csr_word_t                   tcfg_word;
    csr_field_pkg::csr_word_t                   tval;
    csr_field_pkg::csr_word_t [`CSR_SAVE_N-1:0] save_words;
    logic                                       timer_int;

    csr_mode_ctrl u_mode_ctrl (
        .clk, .rstn, .software_we, .waddr, .we, .wdata,
        .store_state, .restore_state, .ecode_in, .ecode_we,
        .hardware_int, .timer_int,
        .plv, .ecode, .translate_mode, .has_interrupt_cpu, .has_interrupt_idle,
        .crmd_word, .prmd_word, .ecfg_word, .estat_word
    );

    csr_scratch_bank u_scratch_bank (
        .clk, .rstn, .software_we, .waddr, .we, .wdata, .era_in, .era_we,
        .era         (era_out),
        .eentry_word (eentry),
        .save_words
    );

    csr_timer u_timer (
        .clk, .rstn, .software_we, .waddr, .we, .wdata,
        .timer_int, .tcfg_word, .tval
    );

    csr_read_port u_read_port (
        .raddr_a, .raddr_b,
        .crmd_word, .prmd_word, .ecfg_word, .estat_word,
        .era         (era_out),
        .eentry_word (eentry),
        .save_words, .tcfg_word, .tval,
        .rdata_a, .rdata_b
    );

endmodule

/* testbench/csr_checker.sv */
`include "csr_cfg.svh"

module csr_checker (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     software_we,
    input  logic [`CSR_ADDR_W-1:0]   waddr,
    input  csr_field_pkg::csr_word_t we,
    input  csr_field_pkg::csr_word_t wdata,
    input  logic [`CSR_ADDR_W-1:0]   raddr_a,
    input  logic [`CSR_ADDR_W-1:0]   raddr_b,
    input  csr_field_pkg::csr_word_t rdata_a,
    input  csr_field_pkg::csr_word_t rdata_b,
    input  logic                     store_state,
    input  logic                     restore_state,
    input  logic [6:0]               ecode_in,
    input  logic                     ecode_we,
    input  csr_field_pkg::csr_word_t era_in,
    input  logic                     era_we,
    input  logic [`CSR_HWI_N-1:0]    hardware_int,
    input  logic [1:0]               plv,
    input  logic [5:0]               ecode,
    input  csr_field_pkg::csr_word_t era_out,
    input  csr_field_pkg::csr_word_t eentry,
    input  logic [1:0]               translate_mode,
    input  logic                     has_interrupt_cpu,
    input  logic                     has_interrupt_idle,
    output int                       error_count,
    output int                       check_count
);
    import csr_field_pkg::*;

    logic [1:0]  m_plv;
    logic [1:0]  m_pplv;
    logic [1:0]  m_is_sw;
    logic        m_ie;
    logic        m_da;
    logic        m_pg;
    logic        m_pie;
    logic        m_esub;
    logic        m_tint;
    logic [5:0]  m_ecode;
    logic [12:0] m_lie;
    logic [12:0] m_is;
    csr_word_t   m_era;
    csr_word_t   m_eentry;
    csr_word_t   m_tcfg;
    csr_word_t   m_tval;
    csr_word_t   m_save [4];
    csr_word_t   crmd_val;
    csr_word_t   prmd_val;
    csr_word_t   ecfg_val;
    csr_word_t   estat_val;
    csr_word_t   crmd_new;
    csr_word_t   prmd_new;
    csr_word_t   ecfg_new;
    csr_word_t   estat_new;
    csr_word_t   tcfg_new;
    logic        tcfg_load;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    function automatic csr_word_t write_bits(input csr_word_t old, input csr_word_t data,
                                             input csr_word_t mask);
        return (old & ~mask) | (data & mask);
    endfunction

    // bit 12 IPI and bit 10 always 0
    assign m_is      = {1'b0, m_tint, 1'b0, hardware_int, m_is_sw};
    assign crmd_val  = {27'd0, m_pg, m_da, m_ie, m_plv};
    assign prmd_val  = {29'd0, m_pie, m_pplv};
    assign ecfg_val  = {19'd0, m_lie};
    assign estat_val = {9'd0, m_esub, m_ecode, 3'd0, m_is};
    assign crmd_new  = write_bits(crmd_val, wdata, we);
    assign prmd_new  = write_bits(prmd_val, wdata, we);
    assign ecfg_new  = write_bits(ecfg_val, wdata, we);
    assign estat_new = write_bits(estat_val, wdata, we);
    assign tcfg_new  = write_bits(m_tcfg, wdata, we);
    assign tcfg_load = software_we && waddr == 14'h041 && we != '0;

    function automatic csr_word_t model_read(input logic [`CSR_ADDR_W-1:0] addr);
        case (addr)
            14'h000: return crmd_val;
            14'h001: return prmd_val;
            14'h004: return ecfg_val;
            14'h005: return estat_val;
            14'h006: return m_era;
            14'h00c: return m_eentry;
            14'h030: return m_save[0];
            14'h031: return m_save[1];
            14'h032: return m_save[2];
            14'h033: return m_save[3];
            14'h041: return m_tcfg;
            14'h042: return m_tval;
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////
    // reference model

    always @(posedge clk) begin
        if (!rstn) begin
            m_plv   <= 2'd0;
            m_ie    <= 1'b0;
            m_da    <= 1'b1;
            m_pg    <= 1'b0;
            m_pplv  <= 2'd0;
            m_pie   <= 1'b0;
            m_lie   <= '0;
            m_is_sw <= 2'd0;
            m_ecode <= '0;
            m_esub  <= 1'b0;
            m_era   <= '0;
            m_eentry <= '0;
            m_tcfg  <= '0;
            m_tval  <= '0;
            m_tint  <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                m_save[i] <= '0;
            end
        end else begin
            if (restore_state) begin
                m_plv <= m_pplv;
                m_ie  <= m_pie;
            end else if (store_state) begin
                m_plv <= 2'd0;
                m_ie  <= 1'b0;
            end else if (software_we && waddr == 14'h000) begin
                m_plv <= crmd_new[1:0];
                m_ie  <= crmd_new[2];
                // pg/da pair must stay one-hot
                if (crmd_new[4] != crmd_new[3]) begin
                    m_pg <= crmd_new[4];
                    m_da <= crmd_new[3];
                end
            end
            if (store_state) begin
                m_pplv <= m_plv;
                m_pie  <= m_ie;
            end else if (software_we && waddr == 14'h001) begin
                m_pplv <= prmd_new[1:0];
                m_pie  <= prmd_new[2];
            end
            if (software_we && waddr == 14'h004) begin
                m_lie <= ecfg_new[12:0] & 13'h1bff;
            end
            if (ecode_we) begin
                m_ecode <= ecode_in[5:0];
                m_esub  <= (ecode_in[5:0] != 6'd0) && ecode_in[6];
            end else if (software_we && waddr == 14'h005) begin
                m_is_sw <= estat_new[1:0];
            end
            if (era_we) begin
                m_era <= era_in;
            end else if (software_we && waddr == 14'h006) begin
                m_era <= write_bits(m_era, wdata, we);
            end
            if (software_we && waddr == 14'h00c) begin
                m_eentry <= write_bits(m_eentry, wdata, we) & 32'hffff_ffc0;
            end
            // save0..3 live at 0x30..0x33
            if (software_we && waddr[13:2] == 12'h00c) begin
                m_save[waddr[1:0]] <= write_bits(m_save[waddr[1:0]], wdata, we);
            end
            if (software_we && waddr == 14'h041) begin
                m_tcfg <= tcfg_new;
            end
            if (tcfg_load) begin
                m_tval <= {tcfg_new[31:2], 2'b01};
            end else if (m_tcfg[0] && m_tval != '0) begin
                m_tval <= m_tval - 32'd1;
            end else if (m_tcfg[1] && m_tval == '0) begin
                m_tval <= {m_tcfg[31:2], 2'b01};
            end
            if (software_we && waddr == 14'h044 && we[0] && wdata[0]) begin
                m_tint <= 1'b0;
            end else if (!tcfg_load && m_tcfg[0] && m_tval == 32'd1) begin
                m_tint <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // comparison

    task automatic compare(input string name, input csr_word_t got, input csr_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error: %s got %h expected %h at time %0t", name, got, exp, $time);
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            compare("rdata_a", rdata_a, model_read(raddr_a));
            compare("rdata_b", rdata_b, model_read(raddr_b));
            compare("plv", {30'd0, plv}, {30'd0, m_plv});
            compare("ecode", {26'd0, ecode}, {26'd0, m_ecode});
            compare("era_out", era_out, m_era);
            compare("eentry", eentry, m_eentry);
            compare("translate_mode", {30'd0, translate_mode}, {30'd0, m_pg, m_da});
            compare("has_interrupt_idle", {31'd0, has_interrupt_idle}, {31'd0, |m_is});
            compare("has_interrupt_cpu", {31'd0, has_interrupt_cpu},
                    {31'd0, m_ie & (|(m_is & m_lie))});
        end
    end

endmodule

/* testbench/tb_csr.sv */
`include "csr_cfg.svh"

module tb_csr;
    import csr_addr_pkg::*;
    import csr_field_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int T1_CYCLES    = 14;
    localparam int T2_CYCLES    = 400;
    localparam int T3_CYCLES    = 300;
    localparam int T4_CYCLES    = 90;
    localparam int T5_CYCLES    = 300;
    localparam int RUN_LIMIT    = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                                  + T4_CYCLES + T5_CYCLES + 50;
    localparam csr_addr_t UNMAPPED = 'h3f;

    logic                  clk;
    logic                  rstn;
    logic                  software_we;
    csr_addr_e             waddr;
    csr_word_t             we;
    csr_word_t             wdata;
    csr_addr_e             raddr_a;
    csr_addr_e             raddr_b;
    csr_word_t             rdata_a;
    csr_word_t             rdata_b;
    logic                  store_state;
    logic                  restore_state;
    logic [6:0]            ecode_in;
    logic                  ecode_we;
    csr_word_t             era_in;
    logic                  era_we;
    logic [`CSR_HWI_N-1:0] hardware_int;
    plv_t                  plv;
    ecode_t                ecode;
    csr_word_t             era_out;
    csr_word_t             eentry;
    logic [1:0]            translate_mode;
    logic                  has_interrupt_cpu;
    logic                  has_interrupt_idle;
    int                    error_count;
    int                    check_count;
    int                    errors_before;
    int                    tests_run;
    int                    tests_failed;
    int                    cycle_count = 0;
    logic [31:0]           rng;

    csr_top DUT (.*);

    csr_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= RUN_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    ////////////////////////////////////////
    // stimulus helpers

    function automatic logic [31:0] rand32();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    // 0..12 mapped in map order, 13 unmapped
    function automatic csr_addr_e addr_at(input int idx);
        case (idx)
            0:       return CSR_CRMD;
            1:       return CSR_PRMD;
            2:       return CSR_ECFG;
            3:       return CSR_ESTAT;
            4:       return CSR_ERA;
            5:       return CSR_EENTRY;
            6:       return CSR_SAVE0;
            7:       return CSR_SAVE1;
            8:       return CSR_SAVE2;
            9:       return CSR_SAVE3;
            10:      return CSR_TCFG;
            11:      return CSR_TVAL;
            12:      return CSR_TICLR;
            default: return csr_addr_e'(UNMAPPED);
        endcase
    endfunction

    function automatic csr_addr_e scratch_addr(input logic [31:0] r);
        int idx;
        idx = int'(r[31:16] % 16'd7);
        return addr_at(idx == 6 ? 13 : idx + 4);
    endfunction

    function automatic csr_addr_e irq_addr(input logic [31:0] r);
        case (r[31:16] % 16'd5)
            16'd0:   return CSR_ECFG;
            16'd1:   return CSR_ESTAT;
            16'd2:   return CSR_CRMD;
            16'd3:   return CSR_TCFG;
            default: return CSR_TICLR;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
        software_we   = 1'b0;
        store_state   = 1'b0;
        restore_state = 1'b0;
        ecode_we      = 1'b0;
        era_we        = 1'b0;
    endtask

    task automatic write_csr(input csr_addr_e addr, input csr_word_t mask,
                             input csr_word_t data);
        next_cycle();
        software_we = 1'b1;
        waddr       = addr;
        we          = mask;
        wdata       = data;
    endtask

    task automatic end_test(input string name);
        int errs;
        @(negedge clk);
        #1;
        errs = error_count - errors_before;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errs);
        end
        errors_before = error_count;
    endtask

    ////////////////////////////////////////
    // tests

    initial begin
        logic [31:0] r;
        rng           = 32'hac6ef82f;
        rstn          = 1'b0;
        software_we   = 1'b0;
        waddr         = CSR_CRMD;
        we            = '0;
        wdata         = '0;
        raddr_a       = CSR_CRMD;
        raddr_b       = CSR_CRMD;
        store_state   = 1'b0;
        restore_state = 1'b0;
        ecode_in      = '0;
        ecode_we      = 1'b0;
        era_in        = '0;
        era_we        = 1'b0;
        hardware_int  = '0;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rstn = 1'b1;

        for (int i = 0; i < T1_CYCLES; i++) begin
            next_cycle();
            raddr_a = addr_at(i);
            raddr_b = addr_at(13 - i);
        end
        end_test("reset values");

        // era_we against a same-edge software write
        write_csr(CSR_ERA, 32'hffff_ffff, rand32());
        era_we  = 1'b1;
        era_in  = rand32();
        raddr_a = CSR_ERA;
        repeat (T2_CYCLES) begin
            next_cycle();
            r           = rand32();
            software_we = (r[31:30] != 2'b00);
            era_we      = (r[29:28] == 2'b00);
            waddr       = scratch_addr(rand32());
            we          = rand32();
            wdata       = rand32();
            era_in      = rand32();
            raddr_a     = scratch_addr(rand32());
            raddr_b     = scratch_addr(rand32());
        end
        end_test("scratch registers");

        repeat (T3_CYCLES) begin
            next_cycle();
            r             = rand32();
            software_we   = r[31];
            store_state   = (r[30:28] == 3'd0);
            restore_state = (r[30:28] == 3'd1);
            ecode_we      = (r[27:26] == 2'b00);
            ecode_in      = (r[25:24] == 2'b00) ? {r[23], 6'b0} : r[22:16];
            waddr         = addr_at(int'(rand32() >> 30));
            we            = rand32();
            wdata         = rand32();
            raddr_a       = addr_at(int'(rand32() >> 30));
            raddr_b       = addr_at(int'(rand32() >> 30));
        end
        end_test("mode and exception state");

        // one-shot, initval 5
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h15);
        raddr_a = CSR_TVAL;
        raddr_b = CSR_ESTAT;
        repeat (30) next_cycle();
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        next_cycle();
        // periodic, initval 3
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0f);
        repeat (40) next_cycle();
        write_csr(CSR_TICLR, 32'h1, 32'h1);
        repeat (3) next_cycle();
        write_csr(CSR_TCFG, 32'hffff_ffff, 32'h0);
        next_cycle();
        end_test("timer");

        repeat (T5_CYCLES) begin
            next_cycle();
            r             = rand32();
            hardware_int  = r[31:24];
            software_we   = r[23];
            store_state   = (r[22:20] == 3'd0);
            restore_state = (r[22:20] == 3'd1);
            waddr         = irq_addr(rand32());
            we            = rand32();
            // small initval keeps the timer firing
            wdata         = (waddr == CSR_TCFG) ? (rand32() & 32'h3f) : rand32();
            raddr_a       = addr_at(int'(rand32() % 32'd14));
            raddr_b       = addr_at(int'(rand32() % 32'd14));
        end
        end_test("interrupt outputs");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+source
source/csr_addr_pkg.sv
source/csr_field_pkg.sv
source/csr_mode_ctrl.sv
source/csr_scratch_bank.sv
source/csr_timer.sv
source/csr_read_port.sv
source/csr_top.sv
testbench/csr_checker.sv
testbench/tb_csr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CSR testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_csr -f verilog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_csr)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1
